// File: hw/vmul_control_pipe.sv
`timescale 1ns/1ps

module vmul_control_pipe
  import vmul_pkg::*;
(
  input  logic      CLK,
  input  logic      nRST,
  input  mul_req_t  req,
  input  logic      req_valid,
  output mul_ctrl_t ctrl
);

  // addend source before extension
  elem_word_u addend_src;

  // controls entering the pipe
  mul_ctrl_t  stage_d;

  // one entry per product stage
  mul_ctrl_t  stage_q [MUL_LATENCY];

  // addend is the operand not used as multiplicand
  assign addend_src = uses_vs3_mcand(req.op) ? req.vs2 : req.vs3;

  always_comb begin
    stage_d.valid    = req_valid;
    stage_d.op       = req.op;
    stage_d.sew      = req.sew;
    stage_d.high_low = req.high_low;
    stage_d.widen    = req.widen;
    stage_d.negate   = req.negate;
    // addend always sign-extended from element width
    stage_d.addend   = ext_elem(addend_src, req.sew, 1'b1);
  end

  // delay line, shifts every cycle
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < MUL_LATENCY; i++) begin
        stage_q[i]       <= '0;
        // idle op, no fused add
        stage_q[i].op    <= NOT_FUSED_MUL;
        stage_q[i].valid <= 1'b0;
      end
    end else begin
      stage_q[0] <= stage_d;
      for (int i = 1; i < MUL_LATENCY; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  // same age as product
  assign ctrl = stage_q[MUL_LATENCY-1];

endmodule

// File: hw/vmul_pkg.sv
package vmul_pkg;

  // datapath widths
  localparam int XLEN   = 32;
  localparam int PROD_W = 2 * XLEN;

  // product pipeline depth, the control pipeline matches it
  localparam int MUL_LATENCY = 3;

  // element width encoding
  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_t;

  // multiply kinds, fused forms add or subtract an addend
  typedef enum logic [2:0] {
    NOT_FUSED_MUL = 3'd0,
    MACC          = 3'd1,
    NMSAC         = 3'd2,
    MADD          = 3'd3,
    NMSUB         = 3'd4
  } mul_op_t;

  // one source word, read whole or as narrow lanes
  typedef union packed {
    logic [XLEN-1:0]  word;
    logic [3:0][7:0]  lane8;
    logic [1:0][15:0] lane16;
  } elem_word_u;

  // request as presented to the lane
  typedef struct packed {
    mul_op_t    op;
    sew_t       sew;
    // bit 0 for vs1, bit 1 for multiplicand
    logic [1:0] is_signed;
    logic       high_low;
    logic       widen;
    logic       negate;
    elem_word_u vs1;
    elem_word_u vs2;
    elem_word_u vs3;
  } mul_req_t;

  // controls travelling beside the product
  typedef struct packed {
    logic            valid;
    mul_op_t         op;
    sew_t            sew;
    logic            high_low;
    logic            widen;
    logic            negate;
    logic [XLEN-1:0] addend;
  } mul_ctrl_t;

  // madd / nmsub take vs3 as multiplicand and vs2 as addend
  function automatic logic uses_vs3_mcand(mul_op_t op);
    return (op == MADD) || (op == NMSUB);
  endfunction

  // lowest element of the width, sign or zero extended to xlen
  function automatic logic [XLEN-1:0] ext_elem(elem_word_u w, sew_t sew, logic sgn);
    logic [XLEN-1:0] v;
    case (sew)
      SEW8:    v = {{24{sgn & w.lane8[0][7]}}, w.lane8[0]};
      SEW16:   v = {{16{sgn & w.lane16[0][15]}}, w.lane16[0]};
      // full word, nothing to extend
      default: v = w.word;
    endcase
    return v;
  endfunction

endpackage

// File: hw/vmul_product_pipe.sv
`timescale 1ns/1ps

module vmul_product_pipe
  import vmul_pkg::*;
(
  input  logic              CLK,
  input  logic              nRST,
  input  mul_req_t          req,
  output logic [PROD_W-1:0] product
);

  // multiplicand source and its signedness
  elem_word_u      mcand_src;
  logic            mcand_sgn;

  // operands extended to xlen
  logic [XLEN-1:0] vs1_ext;
  logic [XLEN-1:0] mcand_ext;

  // 33 bit signed operands, top bit carries signedness
  logic signed [XLEN:0] op_a_d;
  logic signed [XLEN:0] op_b_d;

  // stage registers
  logic signed [XLEN:0]     op_a_q;
  logic signed [XLEN:0]     op_b_q;
  logic signed [PROD_W-1:0] prod_q;
  logic [PROD_W-1:0]        prod_hold_q;

  // operand swap for madd / nmsub
  always_comb begin
    if (uses_vs3_mcand(req.op)) begin
      mcand_src = req.vs3;
      // vs3 as multiplicand is always treated as signed
      mcand_sgn = 1'b1;
    end else begin
      mcand_src = req.vs2;
      mcand_sgn = req.is_signed[1];
    end
  end

  // narrow elements extended from their lowest lane
  assign vs1_ext   = ext_elem(req.vs1, req.sew, req.is_signed[0]);
  assign mcand_ext = ext_elem(mcand_src, req.sew, mcand_sgn);

  // extra top bit turns unsigned sew32 operands into positive 33 bit values
  assign op_a_d = {req.is_signed[0] & vs1_ext[XLEN-1], vs1_ext};
  assign op_b_d = {mcand_sgn & mcand_ext[XLEN-1], mcand_ext};

  // stage 1, extended operands
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      op_a_q <= '0;
      op_b_q <= '0;
    end else begin
      op_a_q <= op_a_d;
      op_b_q <= op_b_d;
    end
  end

  // stage 2, signed multiply
  // low 64 bits of the 66 bit product are all that is kept
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      prod_q <= '0;
    end else begin
      prod_q <= PROD_W'(op_a_q) * PROD_W'(op_b_q);
    end
  end

  // stage 3, hold to line up with control pipe
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      prod_hold_q <= '0;
    end else begin
      prod_hold_q <= prod_q;
    end
  end

  // meaningful only when ctrl.valid marks it
  assign product = prod_hold_q;

endmodule

// File: hw/vmul_result_stage.sv
`timescale 1ns/1ps

module vmul_result_stage
  import vmul_pkg::*;
(
  input  logic              CLK,
  input  logic              nRST,
  input  logic [PROD_W-1:0] product,
  input  mul_ctrl_t         ctrl,
  output logic [XLEN-1:0]   result,
  output logic              result_valid
);

  // selected product slice, zero extended
  logic [XLEN-1:0] slice;

  // slice after optional negation
  logic [XLEN-1:0] prod_mod;

  // value to register
  logic [XLEN-1:0] result_d;

  // slice by delayed width and flags
  always_comb begin
    slice = '0;
    case (ctrl.sew)
      SEW8: begin
        if (ctrl.high_low) begin
          slice = {24'd0, product[15:8]};
        end else if (ctrl.widen) begin
          // full 16 bit product
          slice = {16'd0, product[15:0]};
        end else begin
          slice = {24'd0, product[7:0]};
        end
      end
      SEW16: begin
        if (ctrl.high_low) begin
          slice = {16'd0, product[31:16]};
        end else if (ctrl.widen) begin
          // full 32 bit product
          slice = product[31:0];
        end else begin
          slice = {16'd0, product[15:0]};
        end
      end
      SEW32: begin
        // no widening at sew32, result would not fit
        if (ctrl.high_low) begin
          slice = product[63:32];
        end else begin
          slice = product[31:0];
        end
      end
      default: begin
        slice = '0;
      end
    endcase
  end

  // two's complement, modulo 2^32
  assign prod_mod = ctrl.negate ? (XLEN'(0) - slice) : slice;

  // fused add / subtract
  always_comb begin
    case (ctrl.op)
      MACC,
      MADD:    result_d = ctrl.addend + prod_mod;
      NMSAC,
      NMSUB:   result_d = ctrl.addend - prod_mod;
      default: result_d = prod_mod;
    endcase
  end

  // output register, one edge after product
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      result       <= '0;
      result_valid <= 1'b0;
    end else begin
      result       <= result_d;
      result_valid <= ctrl.valid;
    end
  end

endmodule

// File: hw/vmul_unit.sv
`timescale 1ns/1ps

module vmul_unit
  import vmul_pkg::*;
(
  input  logic            CLK,
  input  logic            nRST,
  input  mul_req_t        req,
  input  logic            req_valid,
  output logic [XLEN-1:0] result,
  output logic            result_valid
);

  // product of request from MUL_LATENCY edges back
  logic [PROD_W-1:0] product;

  // matching controls and addend
  mul_ctrl_t         ctrl;

  // free running multiplier
  vmul_product_pipe u_product_pipe (
    .CLK     (CLK),
    .nRST    (nRST),
    .req     (req),
    .product (product)
  );

  // only this branch tracks validity
  vmul_control_pipe u_control_pipe (
    .CLK       (CLK),
    .nRST      (nRST),
    .req       (req),
    .req_valid (req_valid),
    .ctrl      (ctrl)
  );

  // slice, negate, fused add, register
  vmul_result_stage u_result_stage (
    .CLK          (CLK),
    .nRST         (nRST),
    .product      (product),
    .ctrl         (ctrl),
    .result       (result),
    .result_valid (result_valid)
  );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the vmul_unit testbench with verilator

set -u

cd "$(dirname "$0")" || exit 1

TOP=vmul_unit_tb
BUILD_DIR=obj_dir
FILE_LIST=vmul_unit.f

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found on PATH"
  exit 1
fi

# build the simulation binary
verilator --binary --assert --timing --top-module "$TOP" \
  -Mdir "$BUILD_DIR" -f "$FILE_LIST"
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator compile failed with status $status"
  exit 1
fi

# run, keeping all assertion failures instead of stopping at the first
output=$("./$BUILD_DIR/V$TOP" +verilator+error+limit+100000 2>&1)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the verdict comes from the testbench output
if echo "$output" | grep -qx "Result: PASSED"; then
  exit 0
else
  exit 1
fi

// File: tb/vmul_unit_checker.sv
`timescale 1ns/1ps

module vmul_unit_checker
  import vmul_pkg::*;
(
  input logic            CLK,
  input logic            nRST,
  input mul_req_t        req,
  input logic            req_valid,
  input logic [XLEN-1:0] result,
  input logic            result_valid
);

  // request to result is product stages plus result register
  localparam int DEPTH = MUL_LATENCY + 1;

  // count of failed assertions
  int err_count = 0;

  // model output for the request on the inputs now
  logic [XLEN-1:0] expected;

  // ones in the low bits
  function automatic logic [63:0] low_mask(int bits);
    return (64'd1 << bits) - 64'd1;
  endfunction

  // low element of a word extended to 64 bits
  function automatic logic [63:0] extend(logic [31:0] w, int bits, logic sgn);
    logic [63:0] v;
    v = {32'd0, w} & low_mask(bits);
    if (sgn && v[bits-1]) begin
      v = v | ~low_mask(bits);
    end
    return v;
  endfunction

  // one request worked out from the unit's rules
  function automatic logic [31:0] ref_model(mul_req_t r);
    int          bits;
    logic        swap;
    logic [31:0] mc;
    logic [31:0] ad;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] p;
    logic [63:0] s;
    logic [63:0] add;
    case (r.sew)
      SEW8:    bits = 8;
      SEW16:   bits = 16;
      default: bits = 32;
    endcase
    // madd and nmsub exchange multiplicand and addend
    swap = (r.op == MADD) || (r.op == NMSUB);
    mc   = swap ? r.vs3.word : r.vs2.word;
    ad   = swap ? r.vs2.word : r.vs3.word;
    a    = extend(r.vs1.word, bits, r.is_signed[0]);
    // vs3 as multiplicand counts as signed
    b    = extend(mc, bits, swap | r.is_signed[1]);
    // low 64 bits of the true product
    p    = a * b;
    if (r.high_low) begin
      s = (p >> bits) & low_mask(bits);
    end else if (r.widen && bits < 32) begin
      s = p & low_mask(2 * bits);
    end else begin
      s = p & low_mask(bits);
    end
    if (r.negate) begin
      s = -s;
    end
    add = extend(ad, bits, 1'b1);
    case (r.op)
      MACC, MADD:   s = add + s;
      NMSAC, NMSUB: s = add - s;
      default: begin
      end
    endcase
    return s[31:0];
  endfunction

  assign expected = ref_model(req);

  // result_valid exactly four edges after each request and never otherwise
  a_valid_timing: assert property (@(posedge CLK) disable iff (!nRST)
    result_valid == $past(req_valid, DEPTH))
    else begin
      err_count++;
      $error("CHECK FAILED at %0t: result_valid out of step with requests", $time);
    end

  // value matches the model of the request four edges back
  a_result_value: assert property (@(posedge CLK) disable iff (!nRST)
    $past(req_valid, DEPTH) |-> (result == $past(expected, DEPTH)))
    else begin
      err_count++;
      $error("CHECK FAILED at %0t: result differs from reference model", $time);
    end

  // outputs clear on the edge after any reset cycle
  a_reset_clear: assert property (@(posedge CLK)
    !nRST |=> (!result_valid && result == '0))
    else begin
      err_count++;
      $error("CHECK FAILED at %0t: outputs not cleared by reset", $time);
    end

endmodule

bind vmul_unit vmul_unit_checker u_checker (
  .CLK          (CLK),
  .nRST         (nRST),
  .req          (req),
  .req_valid    (req_valid),
  .result       (result),
  .result_valid (result_valid)
);

// File: tb/vmul_unit_tb.sv
`timescale 1ns/1ps

module vmul_unit_tb
  import vmul_pkg::*;
();

  localparam int CLK_PERIOD  = 10;
  localparam int SEED        = 32'hc710;
  // 12 plain, 6 high, 8 widening, 24 fused
  localparam int N_DIRECTED  = 50;
  localparam int N_RANDOM    = 200;
  // reset, idle gaps and drain
  localparam int MARGIN_NS   = 1000;
  localparam int WATCHDOG_NS = (N_DIRECTED + N_RANDOM) * CLK_PERIOD + MARGIN_NS;

  logic            CLK;
  logic            nRST;
  mul_req_t        req;
  logic            req_valid;
  logic [XLEN-1:0] result;
  logic            result_valid;

  int seed;
  int n_issued;
  int err_total;

  vmul_unit UUT (
    .CLK          (CLK),
    .nRST         (nRST),
    .req          (req),
    .req_valid    (req_valid),
    .result       (result),
    .result_valid (result_valid)
  );

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  // one valid request, launched at the falling edge
  task automatic drive_req(input mul_op_t op, input sew_t sew, input logic [1:0] sgn,
                           input logic hl, input logic wd, input logic ng,
                           input logic [31:0] a, input logic [31:0] b,
                           input logic [31:0] c);
    @(negedge CLK);
    req.op        = op;
    req.sew       = sew;
    req.is_signed = sgn;
    req.high_low  = hl;
    req.widen     = wd;
    req.negate    = ng;
    req.vs1.word  = a;
    req.vs2.word  = b;
    req.vs3.word  = c;
    req_valid     = 1'b1;
    n_issued++;
  endtask

  // no request, operands keep moving through the product pipe
  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(negedge CLK);
      req_valid    = 1'b0;
      req.vs1.word = $random(seed);
    end
  endtask

  // low sew bits, every width and signedness
  task automatic plain_products();
    for (int w = 0; w < 3; w++) begin
      for (int s = 0; s < 4; s++) begin
        drive_req(NOT_FUSED_MUL, sew_t'(w), 2'(s), 1'b0, 1'b0, 1'b0,
                  32'h1234_56f3, 32'h89ab_cd9e, 32'h5555_5555);
      end
    end
  endtask

  // upper half, unsigned then signed
  task automatic high_products();
    for (int w = 0; w < 3; w++) begin
      drive_req(NOT_FUSED_MUL, sew_t'(w), 2'b00, 1'b1, 1'b0, 1'b0,
                32'hfedc_ba87, 32'h8765_4381, 32'h0);
      drive_req(NOT_FUSED_MUL, sew_t'(w), 2'b11, 1'b1, 1'b0, 1'b0,
                32'hfedc_ba87, 32'h8765_4381, 32'h0);
    end
  endtask

  // 2*sew result, sew8 and sew16 only
  task automatic widening_products();
    for (int w = 0; w < 2; w++) begin
      for (int s = 0; s < 4; s++) begin
        drive_req(NOT_FUSED_MUL, sew_t'(w), 2'(s), 1'b0, 1'b1, 1'b0,
                  32'hc3a5_ff81, 32'h7e01_80fe, 32'h0);
      end
    end
  endtask

  // each fused op, with and without negation
  task automatic fused_products();
    for (int op = 1; op < 5; op++) begin
      for (int ng = 0; ng < 2; ng++) begin
        for (int w = 0; w < 3; w++) begin
          drive_req(mul_op_t'(op), sew_t'(w), 2'(op + ng), 1'b0, 1'b0, 1'(ng),
                    32'h0bad_f00d, 32'h8001_c0de, 32'h0f0f_8f70);
        end
      end
    end
  endtask

  // back to back random requests
  task automatic random_burst(input int count);
    int          r;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    repeat (count) begin
      r = $random(seed);
      a = $random(seed);
      b = $random(seed);
      c = $random(seed);
      drive_req(mul_op_t'($unsigned(r) % 5), sew_t'(($unsigned(r) >> 4) % 3), r[9:8],
                r[10], r[11], r[12], a, b, c);
    end
  endtask

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    CLK       = 1'b0;
    nRST      = 1'b0;
    req       = '0;
    req_valid = 1'b0;
    seed      = SEED;
    n_issued  = 0;
    err_total = 0;
    // reset over two rising edges
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
    // quiet unit, result_valid must stay low
    idle(8);
    plain_products();
    idle(3);
    high_products();
    idle(3);
    widening_products();
    idle(3);
    fused_products();
    idle(3);
    random_burst(N_RANDOM);
    // let the last results leave the pipe
    idle(10);
    err_total = UUT.u_checker.err_count;
    $display("requests %0d, assertion failures %0d", n_issued, err_total);
    if (err_total == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: vmul_unit.f
hw/vmul_pkg.sv
hw/vmul_product_pipe.sv
hw/vmul_control_pipe.sv
hw/vmul_result_stage.sv
hw/vmul_unit.sv
tb/vmul_unit_checker.sv
tb/vmul_unit_tb.sv
